/* source/mbus_ice_pkg.sv */
package mbus_ice_pkg;

	// One MBus address or data word
	typedef logic [31:0] mbus_word_t;

	// One byte on the host frame bus
	typedef logic [7:0] host_byte_t;

	// Board-wide time-tag count
	typedef logic [7:0] time_tag_t;

	// MBus clock divider value
	typedef logic [21:0] clk_div_t;

	// Word as delivered by the layer controller
	typedef struct packed {
		mbus_word_t addr;
		mbus_word_t data;
		logic req;
		logic pend;
		logic fail;
		logic broadcast;
		logic [1:0] ctrl;
	} mbus_rx_word_s;

	// Accumulated status, low nibble of the closing byte
	typedef struct packed {
		logic fail;
		logic broadcast;
		logic [1:0] ctrl;
	} rx_status_s;

	// Host frame bus, level plus per-byte strobe
	typedef struct packed {
		logic valid;
		logic latch;
		host_byte_t data;
	} host_frame_s;

	typedef enum logic [2:0] {
		IDLE,
		HDR_FLAG,
		HDR_TAG,
		RX_LOAD,
		RX_SHIFT,
		RX_CHECK,
		RX_END,
		FAIL_ACK
	} rx_state_e;

endpackage

/* source/mbus_clk_divider.sv */
`timescale 1ns/1ps

module mbus_clk_divider import mbus_ice_pkg::*; #(
	parameter int CLK_DIV_WIDTH = 22
) (
	input logic clk,
	input logic reset,
	input clk_div_t clk_div,
	output logic mbus_clk
);

	logic [CLK_DIV_WIDTH-1:0] div_cnt;
	logic div_hit;

	// Only the low bits take part when the counter is narrower
	assign div_hit = (div_cnt == clk_div[CLK_DIV_WIDTH-1:0]);

	// Half period is clk_div + 1 system cycles
	always_ff @(posedge clk) begin
		if (reset) begin
			div_cnt <= '0;
			mbus_clk <= 1'b0;
		end else if (div_hit) begin
			div_cnt <= '0;
			mbus_clk <= ~mbus_clk;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

endmodule

/* source/rx_sequencer.sv */
`timescale 1ns/1ps

module rx_sequencer import mbus_ice_pkg::*; (
	input logic clk,
	input logic reset,
	input logic rx_req,
	input logic rx_fail,
	input logic word_pend,
	input logic bytes_left_zero,
	output logic load_word,
	output logic shift_byte,
	output logic clear_status,
	output logic sel_flag,
	output logic sel_tag,
	output logic sel_status,
	output logic frame_valid,
	output logic rx_ack,
	output logic incr_ctr
);

	rx_state_e state;
	rx_state_e state_next;
	logic [1:0] req_sync_q;
	logic [2:0] fail_sync_q;
	logic [1:0] state_ctr;
	logic ack_next;
	logic req_seen;
	logic fail_rise;

	// Strobes come from the slower MBus domain
	assign req_seen = req_sync_q[1];

	// Edge only, a held fail must not retrigger from IDLE
	assign fail_rise = fail_sync_q[1] & ~fail_sync_q[2];

	always_ff @(posedge clk) begin
		if (reset) begin
			req_sync_q <= '0;
			fail_sync_q <= '0;
			state <= IDLE;
			rx_ack <= 1'b0;
			state_ctr <= '0;
		end else begin
			req_sync_q <= {req_sync_q[0], rx_req};
			fail_sync_q <= {fail_sync_q[1:0], rx_fail};
			state <= state_next;
			rx_ack <= ack_next;
			// Cycles spent in the current state
			if (state_next != state) begin
				state_ctr <= '0;
			end else begin
				state_ctr <= state_ctr + 2'd1;
			end
		end
	end

	always_comb begin
		state_next = state;
		load_word = 1'b0;
		shift_byte = 1'b0;
		clear_status = 1'b0;
		sel_flag = 1'b0;
		sel_tag = 1'b0;
		sel_status = 1'b0;
		frame_valid = 1'b0;
		ack_next = 1'b0;
		incr_ctr = 1'b0;
		case (state)
			IDLE: begin
				clear_status = 1'b1;
				if (req_seen) begin
					state_next = HDR_FLAG;
				end else if (fail_rise) begin
					state_next = FAIL_ACK;
				end
			end
			HDR_FLAG: begin
				frame_valid = 1'b1;
				sel_flag = 1'b1;
				state_next = HDR_TAG;
			end
			HDR_TAG: begin
				// Tag shown for two cycles, counter bumped on the second
				frame_valid = 1'b1;
				sel_tag = 1'b1;
				if (state_ctr == 2'd1) begin
					incr_ctr = 1'b1;
					state_next = RX_LOAD;
				end
			end
			RX_LOAD: begin
				frame_valid = 1'b1;
				load_word = 1'b1;
				ack_next = 1'b1;
				state_next = RX_SHIFT;
			end
			RX_SHIFT: begin
				frame_valid = 1'b1;
				shift_byte = 1'b1;
				if (bytes_left_zero) begin
					state_next = RX_CHECK;
				end
			end
			RX_CHECK: begin
				// Waits here as long as the controller needs
				frame_valid = 1'b1;
				if (!word_pend) begin
					state_next = RX_END;
				end else if (req_seen) begin
					state_next = RX_LOAD;
				end
			end
			RX_END: begin
				frame_valid = 1'b1;
				sel_status = 1'b1;
				state_next = IDLE;
			end
			FAIL_ACK: begin
				ack_next = 1'b1;
				if (state_ctr == 2'd2) begin
					state_next = IDLE;
				end
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

endmodule

/* source/rx_word_shifter.sv */
`timescale 1ns/1ps

module rx_word_shifter import mbus_ice_pkg::*; #(
	parameter host_byte_t FRAME_FLAG = 8'h62
) (
	input logic clk,
	input logic reset,
	input mbus_rx_word_s word,
	input time_tag_t time_tag,
	input logic load_word,
	input logic shift_byte,
	input logic clear_status,
	input logic sel_flag,
	input logic sel_tag,
	input logic sel_status,
	input logic frame_valid,
	output logic word_pend,
	output logic bytes_left_zero,
	output host_frame_s frame
);

	logic [63:0] byte_sr;
	// Bytes left after the one on the output
	logic [2:0] bytes_left;
	logic first_word;
	logic sel_tag_q;
	rx_status_s status;

	assign bytes_left_zero = (bytes_left == 3'd0);

	always_ff @(posedge clk) begin
		if (load_word) begin
			// Address only goes out with the first word
			byte_sr <= first_word ? {word.addr, word.data} : {word.data, 32'd0};
		end else if (shift_byte) begin
			byte_sr <= {byte_sr[55:0], 8'h00};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			bytes_left <= '0;
			first_word <= 1'b1;
			sel_tag_q <= 1'b0;
			word_pend <= 1'b0;
			status <= '0;
		end else begin
			sel_tag_q <= sel_tag;
			if (clear_status) begin
				first_word <= 1'b1;
				status <= '0;
			end else if (load_word) begin
				first_word <= 1'b0;
				word_pend <= word.pend;
				bytes_left <= first_word ? 3'd7 : 3'd3;
				status <= status | {word.fail, word.broadcast, word.ctrl};
			end else if (shift_byte) begin
				bytes_left <= bytes_left - 3'd1;
			end
		end
	end

	always_comb begin
		frame.valid = frame_valid;
		// Tag is latched once, on its first cycle
		frame.latch = sel_flag | (sel_tag & ~sel_tag_q) | shift_byte | sel_status;
		if (sel_flag) begin
			frame.data = FRAME_FLAG;
		end else if (sel_tag) begin
			frame.data = time_tag;
		end else if (sel_status) begin
			frame.data = {4'b0000, status};
		end else begin
			frame.data = byte_sr[63:56];
		end
	end

endmodule

/* source/mbus_rx_bridge.sv */
`timescale 1ns/1ps

module mbus_rx_bridge import mbus_ice_pkg::*; #(
	parameter host_byte_t FRAME_FLAG = 8'h62,
	parameter int CLK_DIV_WIDTH = 22
) (
	input logic clk,
	input logic reset,
	input clk_div_t clk_div,
	output logic mbus_clk,
	input mbus_rx_word_s rx_word,
	output logic rx_ack,
	input time_tag_t global_counter,
	output logic incr_ctr,
	output host_frame_s frame
);

	logic load_word;
	logic shift_byte;
	logic clear_status;
	logic sel_flag;
	logic sel_tag;
	logic sel_status;
	logic frame_valid;
	logic word_pend;
	logic bytes_left_zero;

	mbus_clk_divider #(
		.CLK_DIV_WIDTH(CLK_DIV_WIDTH)
	) mbus_clk_divider_i (
		.clk(clk),
		.reset(reset),
		.clk_div(clk_div),
		.mbus_clk(mbus_clk)
	);

	rx_sequencer rx_sequencer_i (
		.clk(clk),
		.reset(reset),
		.rx_req(rx_word.req),
		.rx_fail(rx_word.fail),
		.word_pend(word_pend),
		.bytes_left_zero(bytes_left_zero),
		.load_word(load_word),
		.shift_byte(shift_byte),
		.clear_status(clear_status),
		.sel_flag(sel_flag),
		.sel_tag(sel_tag),
		.sel_status(sel_status),
		.frame_valid(frame_valid),
		.rx_ack(rx_ack),
		.incr_ctr(incr_ctr)
	);

	// Payload side sees the raw word, held stable until rx_ack
	rx_word_shifter #(
		.FRAME_FLAG(FRAME_FLAG)
	) rx_word_shifter_i (
		.clk(clk),
		.reset(reset),
		.word(rx_word),
		.time_tag(global_counter),
		.load_word(load_word),
		.shift_byte(shift_byte),
		.clear_status(clear_status),
		.sel_flag(sel_flag),
		.sel_tag(sel_tag),
		.sel_status(sel_status),
		.frame_valid(frame_valid),
		.word_pend(word_pend),
		.bytes_left_zero(bytes_left_zero),
		.frame(frame)
	);

endmodule

/* sim/mbus_rx_bridge_assertions.sv */
`timescale 1ns/1ps

module mbus_rx_bridge_assertions import mbus_ice_pkg::*; (
	input logic clk,
	input logic reset,
	input rx_state_e state,
	input logic rx_ack,
	input logic frame_valid,
	input logic incr_ctr,
	input logic sel_flag,
	input logic sel_tag,
	input logic shift_byte,
	input logic sel_status
);

	logic latch_any;

	// Any strobe that can raise the host latch
	assign latch_any = sel_flag | sel_tag | shift_byte | sel_status;

	ack_single_pulse: assert property (@(posedge clk) disable iff (reset)
		(rx_ack && state != FAIL_ACK) |=> !rx_ack)
		else $error("rx_ack held past one cycle outside FAIL_ACK");

	// Flag byte opens the window and later bytes stay inside it
	latch_in_frame: assert property (@(posedge clk) disable iff (reset)
		latch_any |-> frame_valid && (sel_flag ? !$past(frame_valid) : $past(frame_valid)))
		else $error("host latch strobe outside the valid window");

	// Counter bump lands on the second tag cycle
	incr_in_frame: assert property (@(posedge clk) disable iff (reset)
		incr_ctr |-> frame_valid && sel_tag && $past(sel_tag))
		else $error("incr_ctr outside the valid window");

endmodule

bind rx_sequencer mbus_rx_bridge_assertions rx_sequencer_checks (
	.clk(clk),
	.reset(reset),
	.state(state),
	.rx_ack(rx_ack),
	.frame_valid(frame_valid),
	.incr_ctr(incr_ctr),
	.sel_flag(sel_flag),
	.sel_tag(sel_tag),
	.shift_byte(shift_byte),
	.sel_status(sel_status)
);

/* sim/mbus_rx_bridge_tb.sv */
`timescale 1ns/1ps

module mbus_rx_bridge_tb import mbus_ice_pkg::*; ();

	localparam host_byte_t FLAG = 8'h62;
	localparam int WAIT_LIMIT = 200;

	logic clk;
	logic reset;
	clk_div_t clk_div;
	logic mbus_clk;
	mbus_rx_word_s rx_word;
	logic rx_ack;
	time_tag_t global_counter = 8'h5a;
	logic incr_ctr;
	host_frame_s frame;
	logic incr_q = 1'b0;

	host_byte_t got_bytes[$];
	host_byte_t exp_bytes[$];
	mbus_rx_word_s msg_words[$];
	int valid_cycles;
	int incr_pulses;
	int ack_cycles;
	int error_count = 0;
	int tests_run = 0;
	bit timed_out = 1'b0;

	mbus_rx_bridge #(
		.FRAME_FLAG(FLAG),
		.CLK_DIV_WIDTH(22)
	) mbus_rx_bridge_i (
		.clk(clk),
		.reset(reset),
		.clk_div(clk_div),
		.mbus_clk(mbus_clk),
		.rx_word(rx_word),
		.rx_ack(rx_ack),
		.global_counter(global_counter),
		.incr_ctr(incr_ctr),
		.frame(frame)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Board-wide tag counter, bumped after each incr_ctr pulse
	always @(negedge clk) begin
		incr_q = incr_ctr;
	end

	always @(posedge clk) begin
		if (reset) begin
			global_counter <= 8'h5a;
		end else if (incr_q) begin
			global_counter <= global_counter + 8'd1;
		end
	end

	task automatic compare_byte(input host_byte_t got, input host_byte_t exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
			error_count++;
		end
	endtask

	task automatic compare_status(input rx_status_s got, input rx_status_s exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
			error_count++;
		end
	endtask

	task automatic compare_count(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			error_count++;
		end
	endtask

	function automatic mbus_rx_word_s new_word(input logic pend);
		mbus_rx_word_s w;
		w = '0;
		w.addr = $urandom();
		w.data = $urandom();
		w.req = 1'b1;
		w.pend = pend;
		return w;
	endfunction

	// Controller model, holds the word until rx_ack
	task automatic send_word(input mbus_rx_word_s w);
		int waited;
		@(posedge clk);
		rx_word <= w;
		waited = 0;
		@(negedge clk);
		while (!rx_ack && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		if (!rx_ack) begin
			$display("Timeout: the controller model got no rx_ack at %0t ns", $time);
			timed_out = 1'b1;
		end
		@(posedge clk);
		rx_word <= '0;
	endtask

	task automatic send_message();
		foreach (msg_words[i]) begin
			if (!timed_out) begin
				send_word(msg_words[i]);
			end
		end
	endtask

	// Host side, gathers latched bytes over one valid window
	task automatic collect_frame();
		int waited;
		got_bytes.delete();
		valid_cycles = 0;
		incr_pulses = 0;
		ack_cycles = 0;
		waited = 0;
		@(negedge clk);
		while (!frame.valid && waited < WAIT_LIMIT) begin
			@(negedge clk);
			waited++;
		end
		waited = 0;
		while (frame.valid && waited < WAIT_LIMIT) begin
			valid_cycles++;
			if (frame.latch) begin
				got_bytes.push_back(frame.data);
			end
			incr_pulses += int'(incr_ctr);
			ack_cycles += int'(rx_ack);
			@(negedge clk);
			waited++;
		end
		if (waited == 0 || frame.valid) begin
			$display("Timeout: the host frame did not open and close at %0t ns", $time);
			timed_out = 1'b1;
		end
	endtask

	task automatic push_word(input mbus_word_t w);
		for (int i = 3; i >= 0; i--) begin
			exp_bytes.push_back(w[8*i +: 8]);
		end
	endtask

	task automatic run_and_check(input rx_status_s exp_status, input int exp_valid);
		time_tag_t tag;
		int last;
		tag = global_counter;
		fork
			send_message();
			collect_frame();
		join
		// Flag and tag, address only with the first word
		exp_bytes.delete();
		exp_bytes.push_back(FLAG);
		exp_bytes.push_back(tag);
		foreach (msg_words[i]) begin
			if (i == 0) begin
				push_word(msg_words[i].addr);
			end
			push_word(msg_words[i].data);
		end
		last = exp_bytes.size();
		compare_count(got_bytes.size(), last + 1, "latched byte count");
		if (got_bytes.size() == last + 1) begin
			foreach (exp_bytes[i]) begin
				compare_byte(got_bytes[i], exp_bytes[i], $sformatf("byte %0d", i));
			end
			compare_status(rx_status_s'(got_bytes[last][3:0]), exp_status, "status byte");
			compare_count(int'(got_bytes[last][7:4]), 0, "status upper nibble");
		end
		compare_count(incr_pulses, 1, "incr_ctr pulses");
		compare_count(ack_cycles, msg_words.size(), "rx_ack cycles");
		if (exp_valid > 0) begin
			compare_count(valid_cycles, exp_valid, "valid window cycles");
		end
	endtask

	task automatic finish_test(input string name, input int err_start);
		tests_run++;
		$display("%-18s %0d errors", name, error_count - err_start);
	endtask

	task automatic test_single_word();
		int err_start;
		err_start = error_count;
		msg_words.delete();
		msg_words.push_back(new_word(1'b0));
		run_and_check(rx_status_s'(4'b0000), 14);
		finish_test("single_word", err_start);
	endtask

	task automatic test_pending_words();
		int err_start;
		err_start = error_count;
		msg_words.delete();
		msg_words.push_back(new_word(1'b1));
		msg_words.push_back(new_word(1'b1));
		msg_words.push_back(new_word(1'b0));
		run_and_check(rx_status_s'(4'b0000), 0);
		finish_test("pending_words", err_start);
	endtask

	task automatic test_status_accumulate();
		int err_start;
		mbus_rx_word_s w0;
		mbus_rx_word_s w1;
		mbus_rx_word_s w2;
		err_start = error_count;
		w0 = new_word(1'b1);
		w0.broadcast = 1'b1;
		w1 = new_word(1'b1);
		w1.ctrl = 2'b01;
		w2 = new_word(1'b0);
		w2.fail = 1'b1;
		w2.ctrl = 2'b10;
		msg_words = '{w0, w1, w2};
		run_and_check(rx_status_s'(4'b1111), 0);
		// Next message must start from a clean status
		msg_words.delete();
		msg_words.push_back(new_word(1'b0));
		run_and_check(rx_status_s'(4'b0000), 14);
		finish_test("status_accumulate", err_start);
	endtask

	task automatic watch_fail_ack();
		ack_cycles = 0;
		valid_cycles = 0;
		repeat (24) begin
			@(negedge clk);
			ack_cycles += int'(rx_ack);
			valid_cycles += int'(frame.valid);
		end
	endtask

	task automatic test_fail_only();
		int err_start;
		mbus_rx_word_s w;
		err_start = error_count;
		w = '0;
		w.fail = 1'b1;
		fork
			send_word(w);
			watch_fail_ack();
		join
		compare_count(ack_cycles, 3, "rx_ack cycles for lone fail");
		compare_count(valid_cycles, 0, "valid cycles for lone fail");
		msg_words.delete();
		msg_words.push_back(new_word(1'b0));
		run_and_check(rx_status_s'(4'b0000), 14);
		finish_test("fail_only", err_start);
	endtask

	task automatic wait_toggle(output int cycles);
		logic prev;
		prev = mbus_clk;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (mbus_clk == prev && cycles < 64);
		if (mbus_clk == prev) begin
			$display("Timeout: mbus_clk stopped toggling at %0t ns", $time);
			timed_out = 1'b1;
		end
	endtask

	task automatic test_divider();
		int err_start;
		int half;
		int divs[3] = '{0, 3, 9};
		err_start = error_count;
		// Rising order keeps the counter below each new compare value
		foreach (divs[i]) begin
			@(posedge clk);
			clk_div <= clk_div_t'(divs[i]);
			@(negedge clk);
			wait_toggle(half);
			wait_toggle(half);
			wait_toggle(half);
			compare_count(half, divs[i] + 1, $sformatf("half period, clk_div %0d", divs[i]));
		end
		finish_test("divider", err_start);
	endtask

	initial begin
		void'($urandom(23));
		reset = 1'b1;
		rx_word = '0;
		clk_div = '0;
		repeat (16) @(posedge clk);
		reset <= 1'b0;
		repeat (4) @(posedge clk);
		if (!timed_out) test_single_word();
		if (!timed_out) test_pending_words();
		if (!timed_out) test_status_accumulate();
		if (!timed_out) test_fail_only();
		if (!timed_out) test_divider();
		$display("%0d tests run, %0d errors, timeout %0d", tests_run, error_count, timed_out);
		if (error_count == 0 && !timed_out) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

/* filelist.f */
source/mbus_ice_pkg.sv
source/mbus_clk_divider.sv
source/rx_sequencer.sv
source/rx_word_shifter.sv
source/mbus_rx_bridge.sv
sim/mbus_rx_bridge_assertions.sv
sim/mbus_rx_bridge_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f filelist.f --top-module mbus_rx_bridge_tb -Mdir obj_dir
	./obj_dir/Vmbus_rx_bridge_tb | tee sim.log
	grep -qx "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
